//--- tb.f
logic/snake_pkg.sv
logic/button_if.sv
logic/button_conditioner.sv
logic/segment_walker.sv
logic/digit_scanner.sv
logic/snake_top.sv
test/snake_assertions.sv
test/snake_tb.sv

//--- test/snake_tb.sv
`timescale 1ns/1ps

module snake_tb
    import snake_pkg::*;
();

    localparam int RESET_CYCLES    = 10;
    localparam int PRESS_HOLD      = 6;
    localparam int RELEASE_CYCLES  = 6;
    localparam int SHORT_HOLD      = 2;
    localparam int SETTLE_CYCLES   = 4 * SCAN_CYCLES + 4;
    localparam int IDLE_WAIT       = (IDLE_TICKS + 1) * TICK_CYCLES;
    localparam int RANDOM_PRESSES  = 200;
    localparam int PRESS_TOTAL     = RANDOM_PRESSES + 5;
    localparam int WATCHDOG_CYCLES = 2 * (PRESS_TOTAL * 30 + RESET_CYCLES + 3 * IDLE_WAIT);

    localparam logic [1:0] BTN_RIGHT = 2'd0;
    localparam logic [1:0] BTN_LEFT  = 2'd1;
    localparam logic [1:0] BTN_UP    = 2'd2;
    localparam logic [1:0] BTN_DOWN  = 2'd3;

    logic               clk;
    logic               rst;
    logic               right;
    logic               left;
    logic               up;
    logic               down;
    logic [DIGIT_W-1:0] digit;
    logic [SEG_W-1:0]   segments;

    // Reference game state
    logic              model_moving;
    logic [POS_W-1:0]  model_pos;
    logic [HEAD_W-1:0] model_head;

    int    seed;
    int    checks;
    int    errors;
    int    test_mark;
    string test_name;

    snake_top UUT (
        .clk      (clk),
        .rst      (rst),
        .right    (right),
        .left     (left),
        .up       (up),
        .down     (down),
        .digit    (digit),
        .segments (segments)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task step_cycle();
        @(posedge clk);
        #2;
    endtask

    task drive_button(input logic [1:0] button, input logic level);
        case (button)
            BTN_RIGHT: right = level;
            BTN_LEFT:  left  = level;
            BTN_UP:    up    = level;
            default:   down  = level;
        endcase
    endtask

    task press(input logic [1:0] button, input int hold);
        drive_button(button, 1'b1);
        repeat (hold) step_cycle();
        drive_button(button, 1'b0);
        repeat (RELEASE_CYCLES) step_cycle();
    endtask

    task settle();
        repeat (SETTLE_CYCLES) step_cycle();
    endtask

    task set_model(input logic [POS_W-1:0] pos, input logic [HEAD_W-1:0] head);
        model_pos  = pos;
        model_head = head;
    endtask

    // Step table keyed on position, heading and button
    task model_press(input logic [1:0] button);
        if (model_moving) begin
            if (button == BTN_DOWN) begin
                model_moving = 1'b0;
                set_model(POS_G, HEAD_LEFT);
            end else begin
                case ({model_pos, model_head, button})
                    {POS_A, HEAD_RIGHT, BTN_RIGHT}: set_model(POS_B, HEAD_DOWN);
                    {POS_A, HEAD_LEFT,  BTN_LEFT}:  set_model(POS_F, HEAD_DOWN);
                    {POS_B, HEAD_UP,    BTN_LEFT}:  set_model(POS_A, HEAD_LEFT);
                    {POS_B, HEAD_DOWN,  BTN_RIGHT}: set_model(POS_G, HEAD_LEFT);
                    {POS_B, HEAD_DOWN,  BTN_UP}:    set_model(POS_C, HEAD_DOWN);
                    {POS_C, HEAD_UP,    BTN_LEFT}:  set_model(POS_G, HEAD_LEFT);
                    {POS_C, HEAD_UP,    BTN_UP}:    set_model(POS_B, HEAD_UP);
                    {POS_C, HEAD_DOWN,  BTN_RIGHT}: set_model(POS_D, HEAD_DOWN);
                    {POS_D, HEAD_RIGHT, BTN_LEFT}:  set_model(POS_C, HEAD_UP);
                    {POS_D, HEAD_LEFT,  BTN_RIGHT}: set_model(POS_E, HEAD_UP);
                    {POS_E, HEAD_UP,    BTN_RIGHT}: set_model(POS_G, HEAD_RIGHT);
                    {POS_E, HEAD_UP,    BTN_UP}:    set_model(POS_F, HEAD_UP);
                    {POS_E, HEAD_DOWN,  BTN_LEFT}:  set_model(POS_D, HEAD_RIGHT);
                    {POS_F, HEAD_UP,    BTN_RIGHT}: set_model(POS_A, HEAD_RIGHT);
                    {POS_F, HEAD_DOWN,  BTN_LEFT}:  set_model(POS_G, HEAD_RIGHT);
                    {POS_G, HEAD_RIGHT, BTN_LEFT}:  set_model(POS_B, HEAD_UP);
                    {POS_G, HEAD_RIGHT, BTN_RIGHT}: set_model(POS_C, HEAD_DOWN);
                    {POS_G, HEAD_LEFT,  BTN_LEFT}:  set_model(POS_E, HEAD_DOWN);
                    {POS_G, HEAD_LEFT,  BTN_RIGHT}: set_model(POS_F, HEAD_UP);
                    default: set_model(model_pos, model_head);
                endcase
            end
        end
    endtask

    // Active low pattern with one segment lit
    function automatic logic [SEG_W-1:0] pattern_of(input logic [POS_W-1:0] pos);
        logic [SEG_W-1:0] seg;
        for (int i = 0; i < SEG_W; i++) begin
            seg[i] = (i != pos);
        end
        return seg;
    endfunction

    task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s (%s): expected %0h, actual %0h",
                     test_name, name, expected, actual);
        end
    endtask

    task automatic read_display(output logic [SEG_W-1:0] seen);
        int cycles;
        cycles = 0;
        while (digit != DIGIT_RIGHT && cycles <= 4 * SCAN_CYCLES) begin
            step_cycle();
            cycles++;
        end
        if (digit != DIGIT_RIGHT) begin
            errors++;
            $display("The rightmost digit was never selected by the scan in %s", test_name);
        end
        seen = segments;
    endtask

    task automatic compare_with_model(input string name);
        logic [SEG_W-1:0] seen;
        read_display(seen);
        check_value(name, pattern_of(model_pos), seen);
    endtask

    task automatic verify_reset_display();
        int cycles;
        cycles = 0;
        check_value("reset_digit", DIGIT_NONE, digit);
        while (digit == DIGIT_NONE && cycles < SCAN_CYCLES + 2) begin
            check_value("reset_segments", SEG_BLANK, segments);
            step_cycle();
            cycles++;
        end
        check_value("first_digit", DIGIT_RIGHT, digit);
        check_value("first_pattern", pattern_of(POS_G), segments);
    endtask

    task start_test(input string name);
        test_mark = errors;
        test_name = name;
    endtask

    task end_test();
        if (errors == test_mark) begin
            $display("%s: pass", test_name);
        end else begin
            $display("%s: fail", test_name);
        end
    endtask

    initial begin
        logic [1:0]       button;
        logic [SEG_W-1:0] seen;
        seed   = 77;
        checks = 0;
        errors = 0;
        rst    = 1'b1;
        right  = 1'b0;
        left   = 1'b0;
        up     = 1'b0;
        down   = 1'b0;
        model_moving = 1'b0;
        set_model(POS_G, HEAD_LEFT);
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("reset_display");
        verify_reset_display();
        end_test();

        start_test("left_from_g");
        repeat (IDLE_WAIT) step_cycle();
        model_moving = 1'b1;
        press(BTN_LEFT, PRESS_HOLD);
        settle();
        model_press(BTN_LEFT);
        read_display(seen);
        check_value("model", pattern_of(model_pos), seen);
        check_value("lands_on_e", pattern_of(POS_E), seen);
        end_test();

        // Left from E heading down would step to D
        start_test("short_press");
        press(BTN_LEFT, SHORT_HOLD);
        settle();
        compare_with_model("model");
        end_test();

        start_test("random_walk");
        for (int n = 0; n < RANDOM_PRESSES; n++) begin
            button = 2'($unsigned($random(seed)) % 3);
            press(button, PRESS_HOLD);
            settle();
            model_press(button);
            compare_with_model("model");
        end
        end_test();

        // Right lands while the idle wait is still running
        start_test("down_to_idle");
        press(BTN_DOWN, PRESS_HOLD);
        model_press(BTN_DOWN);
        press(BTN_RIGHT, PRESS_HOLD);
        model_press(BTN_RIGHT);
        settle();
        read_display(seen);
        check_value("model", pattern_of(model_pos), seen);
        check_value("stays_on_g", pattern_of(POS_G), seen);
        end_test();

        start_test("right_after_idle");
        repeat (IDLE_WAIT) step_cycle();
        model_moving = 1'b1;
        press(BTN_RIGHT, PRESS_HOLD);
        settle();
        model_press(BTN_RIGHT);
        read_display(seen);
        check_value("model", pattern_of(model_pos), seen);
        check_value("lands_on_f", pattern_of(POS_F), seen);
        end_test();

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_assertions.failures);
        if (errors == 0 && UUT.u_assertions.failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- test/snake_assertions.sv
`timescale 1ns/1ps

module snake_assertions
    import snake_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic [DIGIT_W-1:0] digit,
    input logic [SEG_W-1:0]   segments,
    input logic               right_pulse,
    input logic               left_pulse,
    input logic               up_pulse,
    input logic               down_pulse
);

    int failures = 0;

    property single_cycle(p);
        @(posedge clk) disable iff (rst) p |=> !p;
    endproperty

    // At most one digit selected
    digit_single: assert property (@(posedge clk) disable iff (rst)
        digit == DIGIT_NONE || $onehot(~digit))
    else begin
        failures++;
        $error("digit enable has more than one low bit: %b", digit);
    end

    // Only the rightmost digit lights
    blank_elsewhere: assert property (@(posedge clk) disable iff (rst)
        digit != DIGIT_RIGHT |-> segments == SEG_BLANK)
    else begin
        failures++;
        $error("segments lit on a digit other than the rightmost: %b", segments);
    end

    right_once: assert property (single_cycle(right_pulse))
    else begin
        failures++;
        $error("right pulse high for more than one cycle");
    end

    left_once: assert property (single_cycle(left_pulse))
    else begin
        failures++;
        $error("left pulse high for more than one cycle");
    end

    up_once: assert property (single_cycle(up_pulse))
    else begin
        failures++;
        $error("up pulse high for more than one cycle");
    end

    down_once: assert property (single_cycle(down_pulse))
    else begin
        failures++;
        $error("down pulse high for more than one cycle");
    end

endmodule

bind snake_top snake_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .digit       (digit),
    .segments    (segments),
    .right_pulse (btn_bus.right),
    .left_pulse  (btn_bus.left),
    .up_pulse    (btn_bus.up),
    .down_pulse  (btn_bus.down)
);

//--- logic/snake_top.sv
`timescale 1ns/1ps

module snake_top
    import snake_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               right,
    input  logic               left,
    input  logic               up,
    input  logic               down,
    output logic [DIGIT_W-1:0] digit,
    output logic [SEG_W-1:0]   segments
);

    logic [SEG_W-1:0] pattern;

    // Button pulses
    button_if btn_bus ();

    button_conditioner u_conditioner (
        .clk   (clk),
        .rst   (rst),
        .right (right),
        .left  (left),
        .up    (up),
        .down  (down),
        .btn   (btn_bus.source)
    );

    segment_walker u_walker (
        .clk     (clk),
        .rst     (rst),
        .btn     (btn_bus.sink),
        .pattern (pattern)
    );

    digit_scanner u_scanner (
        .clk      (clk),
        .rst      (rst),
        .pattern  (pattern),
        .digit    (digit),
        .segments (segments)
    );

endmodule

//--- logic/digit_scanner.sv
`timescale 1ns/1ps

module digit_scanner
    import snake_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [SEG_W-1:0]   pattern,
    output logic [DIGIT_W-1:0] digit,
    output logic [SEG_W-1:0]   segments
);

    logic [SCAN_W-1:0]  scan_div;
    logic               step;
    logic [DIGIT_W-1:0] digit_next;

    assign step = (scan_div == SCAN_W'(SCAN_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_div <= '0;
        end else if (step) begin
            scan_div <= '0;
        end else begin
            scan_div <= scan_div + 1'b1;
        end
    end

    // Rotate the single low bit toward the left digit
    always_comb begin
        if (digit == DIGIT_NONE) begin
            digit_next = DIGIT_RIGHT;
        end else begin
            digit_next = {digit[DIGIT_W-2:0], digit[DIGIT_W-1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digit    <= DIGIT_NONE;
            segments <= SEG_BLANK;
        end else if (step) begin
            digit <= digit_next;
            // Only the rightmost digit carries the game
            if (digit_next == DIGIT_RIGHT) begin
                segments <= pattern;
            end else begin
                segments <= SEG_BLANK;
            end
        end
    end

endmodule

//--- logic/segment_walker.sv
`timescale 1ns/1ps

module segment_walker
    import snake_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    button_if.sink           btn,
    output logic [SEG_W-1:0] pattern
);

    // Low while idle
    logic              moving;
    logic [TICK_W-1:0] tick_div;
    logic              tick;
    logic [IDLE_W-1:0] tick_cnt;
    logic [POS_W-1:0]  pos;
    logic [HEAD_W-1:0] head;
    logic [POS_W-1:0]  pos_next;
    logic [HEAD_W-1:0] head_next;

    assign tick = (tick_div == TICK_W'(TICK_CYCLES - 1));

    // Free-running game tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_div <= '0;
        end else if (tick) begin
            tick_div <= '0;
        end else begin
            tick_div <= tick_div + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            moving   <= 1'b0;
            tick_cnt <= '0;
            pos      <= POS_G;
            head     <= HEAD_LEFT;
        end else if (!moving) begin
            if (tick_cnt == IDLE_W'(IDLE_TICKS)) begin
                moving <= 1'b1;
            end else if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end else if (btn.down) begin
            // Back to idle, restart from the middle bar
            moving   <= 1'b0;
            tick_cnt <= '0;
            pos      <= POS_G;
            head     <= HEAD_LEFT;
        end else begin
            pos  <= pos_next;
            head <= head_next;
        end
    end

    // Step rule, earlier branch wins on coincident pulses
    always_comb begin
        pos_next  = pos;
        head_next = head;
        case (pos)
            POS_A: begin
                if (head == HEAD_RIGHT && btn.right) begin
                    pos_next  = POS_B;
                    head_next = HEAD_DOWN;
                end else if (head == HEAD_LEFT && btn.left) begin
                    pos_next  = POS_F;
                    head_next = HEAD_DOWN;
                end
            end
            POS_B: begin
                if (head == HEAD_UP && btn.left) begin
                    pos_next  = POS_A;
                    head_next = HEAD_LEFT;
                end else if (head == HEAD_DOWN && btn.right) begin
                    pos_next  = POS_G;
                    head_next = HEAD_LEFT;
                end else if (head == HEAD_DOWN && btn.up) begin
                    pos_next  = POS_C;
                    head_next = HEAD_DOWN;
                end
            end
            POS_C: begin
                if (head == HEAD_UP && btn.left) begin
                    pos_next  = POS_G;
                    head_next = HEAD_LEFT;
                end else if (head == HEAD_UP && btn.up) begin
                    pos_next  = POS_B;
                    head_next = HEAD_UP;
                end else if (head == HEAD_DOWN && btn.right) begin
                    pos_next  = POS_D;
                    head_next = HEAD_DOWN;
                end
            end
            POS_D: begin
                if (head == HEAD_RIGHT && btn.left) begin
                    pos_next  = POS_C;
                    head_next = HEAD_UP;
                end else if (head == HEAD_LEFT && btn.right) begin
                    pos_next  = POS_E;
                    head_next = HEAD_UP;
                end
            end
            POS_E: begin
                if (head == HEAD_UP && btn.right) begin
                    pos_next  = POS_G;
                    head_next = HEAD_RIGHT;
                end else if (head == HEAD_UP && btn.up) begin
                    pos_next  = POS_F;
                    head_next = HEAD_UP;
                end else if (head == HEAD_DOWN && btn.left) begin
                    pos_next  = POS_D;
                    head_next = HEAD_RIGHT;
                end
            end
            POS_F: begin
                if (head == HEAD_UP && btn.right) begin
                    pos_next  = POS_A;
                    head_next = HEAD_RIGHT;
                end else if (head == HEAD_DOWN && btn.left) begin
                    pos_next  = POS_G;
                    head_next = HEAD_RIGHT;
                end
            end
            POS_G: begin
                if (head == HEAD_RIGHT && btn.left) begin
                    pos_next  = POS_B;
                    head_next = HEAD_UP;
                end else if (head == HEAD_RIGHT && btn.right) begin
                    pos_next  = POS_C;
                    head_next = HEAD_DOWN;
                end else if (head == HEAD_LEFT && btn.left) begin
                    pos_next  = POS_E;
                    head_next = HEAD_DOWN;
                end else if (head == HEAD_LEFT && btn.right) begin
                    pos_next  = POS_F;
                    head_next = HEAD_UP;
                end
            end
            default: begin
                // Unused index, recover to the start
                pos_next  = POS_G;
                head_next = HEAD_LEFT;
            end
        endcase
    end

    // One lit segment
    assign pattern = SEG_BLANK & ~(SEG_W'(1) << pos);

endmodule

//--- logic/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner
    import snake_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     right,
    input  logic     left,
    input  logic     up,
    input  logic     down,
    button_if.source btn
);

    logic [BTN_COUNT-1:0]                   level;
    logic [BTN_COUNT-1:0][DEBOUNCE_LEN-1:0] samples;
    logic [BTN_COUNT-1:0]                   stable;
    logic [BTN_COUNT-1:0]                   stable_q;
    logic [BTN_COUNT-1:0]                   pulse;

    assign level = {down, up, left, right};

    // Pressed only once every sample in the window is high
    always_comb begin
        for (int i = 0; i < BTN_COUNT; i++) begin
            stable[i] = &samples[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples  <= '0;
            stable_q <= '0;
            pulse    <= '0;
        end else begin
            for (int i = 0; i < BTN_COUNT; i++) begin
                samples[i] <= {samples[i][DEBOUNCE_LEN-2:0], level[i]};
            end
            stable_q <= stable;
            // Rising edge of the debounced level
            pulse    <= stable & ~stable_q;
        end
    end

    assign btn.right = pulse[0];
    assign btn.left  = pulse[1];
    assign btn.up    = pulse[2];
    assign btn.down  = pulse[3];

endmodule

//--- logic/button_if.sv
`timescale 1ns/1ps

interface button_if;

    // One-cycle press pulses
    logic right;
    logic left;
    logic up;
    logic down;

    modport source (
        output right,
        output left,
        output up,
        output down
    );

    modport sink (
        input right,
        input left,
        input up,
        input down
    );

endinterface

//--- logic/snake_pkg.sv
package snake_pkg;

    // Display, active low on both buses
    localparam int SEG_W   = 7;
    localparam int DIGIT_W = 4;

    localparam logic [SEG_W-1:0]   SEG_BLANK   = 7'b111_1111;
    localparam logic [DIGIT_W-1:0] DIGIT_NONE  = 4'b1111;
    localparam logic [DIGIT_W-1:0] DIGIT_RIGHT = 4'b1110;

    // Segment positions, index equals the segment bit
    localparam int POS_W = 3;

    localparam logic [POS_W-1:0] POS_A = 3'd0;
    localparam logic [POS_W-1:0] POS_B = 3'd1;
    localparam logic [POS_W-1:0] POS_C = 3'd2;
    localparam logic [POS_W-1:0] POS_D = 3'd3;
    localparam logic [POS_W-1:0] POS_E = 3'd4;
    localparam logic [POS_W-1:0] POS_F = 3'd5;
    localparam logic [POS_W-1:0] POS_G = 3'd6;

    localparam int HEAD_W = 2;

    localparam logic [HEAD_W-1:0] HEAD_RIGHT = 2'd0;
    localparam logic [HEAD_W-1:0] HEAD_LEFT  = 2'd1;
    localparam logic [HEAD_W-1:0] HEAD_UP    = 2'd2;
    localparam logic [HEAD_W-1:0] HEAD_DOWN  = 2'd3;

    // Button conditioning
    localparam int BTN_COUNT    = 4;
    localparam int DEBOUNCE_LEN = 4;

    // Timing; a board build wants TICK_CYCLES near 50_000_000
    localparam int TICK_CYCLES = 8;
    localparam int IDLE_TICKS  = 3;
    localparam int SCAN_CYCLES = 4;

    localparam int TICK_W = $clog2(TICK_CYCLES);
    localparam int IDLE_W = $clog2(IDLE_TICKS + 1);
    localparam int SCAN_W = $clog2(SCAN_CYCLES);

endpackage
